//--- Bender.yml
package:
  name: i3c_target

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/i3c_bus_pkg.sv
      - verilog/i3c_target_pkg.sv
      - verilog/bus_monitor.sv
      - verilog/bus_rx_flow.sv
      - verilog/target_fsm.sv
      - verilog/target_regs.sv
      - verilog/i3c_target_top.sv
  - target: test
    files:
      - bench/tb_i3c_target.sv

//--- bench/tb_i3c_target.sv
// Host model uses 16 clocks per SCL bit; read headers are sent but no read data phase is modeled
`timescale 1ns/1ps

module tb_i3c_target;
  import i3c_bus_pkg::*;
  import i3c_target_pkg::*;

  // Room for about 60 frames of 144 clocks each plus margin
  localparam int unsigned timeout_cycles = 20000;
  localparam i3c_addr_t   sta_addr       = 7'h2a;
  localparam i3c_addr_t   dyn_addr       = 7'h51;

  logic        clk;
  logic        rst_n;
  logic        scl;
  logic        sda_host;
  logic        sda_bus;
  logic        cfg_we;
  target_reg_e cfg_addr;
  i3c_byte_t   cfg_wdata;
  logic        queue_full;
  logic        sda_tgt;
  i3c_byte_t   cfg_rdata;
  logic        wvalid;
  i3c_byte_t   wdata;
  logic        bus_start;
  logic        bus_rstart;
  logic        bus_stop;
  i3c_header_u bus_addr;
  logic        bus_addr_valid;
  logic        parity_err;

  logic [31:0] lfsr = 32'hf058_e691;
  int unsigned cycle_cnt = 0;
  int          start_cnt = 0;
  int          rstart_cnt = 0;
  int          stop_cnt = 0;
  int          addr_cnt = 0;
  int          perr_cnt = 0;
  i3c_byte_t   got_q[$];
  i3c_byte_t   exp_q[$];

  // Open-drain line, either side can pull it low
  assign sda_bus = sda_host & sda_tgt;

  always #2 clk = ~clk;

  i3c_target_top i_i3c_target_top (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .scl_i            (scl),
    .sda_i            (sda_bus),
    .cfg_we_i         (cfg_we),
    .cfg_addr_i       (cfg_addr),
    .cfg_wdata_i      (cfg_wdata),
    .rx_queue_full_i  (queue_full),
    .sda_o            (sda_tgt),
    .cfg_rdata_o      (cfg_rdata),
    .rx_queue_wvalid_o(wvalid),
    .rx_queue_wdata_o (wdata),
    .bus_start_o      (bus_start),
    .bus_rstart_o     (bus_rstart),
    .bus_stop_o       (bus_stop),
    .bus_addr_o       (bus_addr),
    .bus_addr_valid_o (bus_addr_valid),
    .parity_err_o     (parity_err)
  );

  // Queue and event monitor
  always @(posedge clk) begin
    cycle_cnt++;
    if (wvalid) begin
      got_q.push_back(wdata);
    end
    start_cnt  += int'(bus_start);
    rstart_cnt += int'(bus_rstart);
    stop_cnt   += int'(bus_stop);
    addr_cnt   += int'(bus_addr_valid);
    perr_cnt   += int'(parity_err);
    if (cycle_cnt >= timeout_cycles) begin
      $display("Timeout, the tests did not finish within %0d cycles", timeout_cycles);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else begin
      $display("MISMATCH time=%0t signal=%s got=%0h expected=%0h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("ERROR at %0t: %s", $time, what);
      abort_run();
    end
  endtask

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic random_byte(output i3c_byte_t b);
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_next(lfsr);
      b    = {b[6:0], lfsr[0]};
    end
  endtask

  // T bit is 1 when the byte holds an even number of ones
  function automatic logic good_tbit(input i3c_byte_t b);
    logic t;
    t = 1'b1;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        t = ~t;
      end
    end
    return t;
  endfunction

  task automatic wait_clocks(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic send_bit(input logic b);
    sda_host = b;
    wait_clocks(4);
    scl = 1'b1;
    wait_clocks(8);
    scl = 1'b0;
    wait_clocks(4);
  endtask

  // SDA released, sampled in the middle of the high phase
  task automatic read_ack(output logic acked);
    sda_host = 1'b1;
    wait_clocks(4);
    scl = 1'b1;
    wait_clocks(4);
    acked = !sda_bus;
    wait_clocks(4);
    scl = 1'b0;
    wait_clocks(4);
  endtask

  task automatic send_start();
    wait_clocks(8);
    sda_host = 1'b0;
    wait_clocks(8);
    scl = 1'b0;
    wait_clocks(4);
  endtask

  task automatic send_rstart();
    sda_host = 1'b1;
    wait_clocks(4);
    scl = 1'b1;
    wait_clocks(4);
    sda_host = 1'b0;
    wait_clocks(4);
    scl = 1'b0;
    wait_clocks(4);
  endtask

  task automatic send_stop();
    sda_host = 1'b0;
    wait_clocks(4);
    scl = 1'b1;
    wait_clocks(8);
    sda_host = 1'b1;
    wait_clocks(8);
  endtask

  task automatic send_header(input i3c_header_u hdr, output logic acked);
    for (int i = 7; i >= 0; i--) begin
      send_bit(hdr.raw[i]);
    end
    read_ack(acked);
  endtask

  task automatic send_frame(input i3c_byte_t b, input logic tbit);
    for (int i = 7; i >= 0; i--) begin
      send_bit(b[i]);
    end
    send_bit(tbit);
  endtask

  task automatic write_reg(input target_reg_e addr, input i3c_byte_t data);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  task automatic read_reg(input target_reg_e addr, output i3c_byte_t data);
    @(negedge clk);
    cfg_addr = addr;
    @(negedge clk);
    data = cfg_rdata;
  endtask

  task automatic clear_counts();
    @(negedge clk);
    start_cnt  = 0;
    rstart_cnt = 0;
    stop_cnt   = 0;
    addr_cnt   = 0;
    perr_cnt   = 0;
    got_q.delete();
    exp_q.delete();
  endtask

  task automatic wait_for_stop(input int count);
    int n;
    n = 0;
    while (stop_cnt < count && n < 64) begin
      @(negedge clk);
      n++;
    end
    check_true(stop_cnt >= count, "STOP condition was never detected");
  endtask

  task automatic check_queue();
    check_eq("queue byte count", got_q.size(), exp_q.size());
    foreach (exp_q[i]) begin
      check_eq("rx_queue_wdata_o", got_q[i], exp_q[i]);
    end
  endtask

  task automatic check_reset_state();
    @(negedge clk);
    check_eq("sda_o", sda_tgt, 1'b1);
    check_eq("rx_queue_wvalid_o", wvalid, 1'b0);
    check_eq("parity_err_o", parity_err, 1'b0);
    check_eq("bus_addr_valid_o", bus_addr_valid, 1'b0);
    check_eq("bus_start_o", bus_start, 1'b0);
    check_eq("bus_rstart_o", bus_rstart, 1'b0);
    check_eq("bus_stop_o", bus_stop, 1'b0);
  endtask

  task automatic test_registers();
    i3c_byte_t rd;
    write_reg(CTRL, 8'h01);
    write_reg(STA_ADDR, {1'b1, sta_addr});
    write_reg(DYN_ADDR, 8'h7f);
    read_reg(DYN_ADDR, rd);
    check_eq("cfg_rdata_o DYN_ADDR", rd, 8'h7f);
    write_reg(DYN_ADDR, {1'b1, dyn_addr});
    read_reg(CTRL, rd);
    check_eq("cfg_rdata_o CTRL", rd, 8'h01);
    read_reg(STA_ADDR, rd);
    check_eq("cfg_rdata_o STA_ADDR", rd, {1'b1, sta_addr});
    read_reg(DYN_ADDR, rd);
    check_eq("cfg_rdata_o DYN_ADDR", rd, {1'b1, dyn_addr});
    read_reg(STATUS, rd);
    check_eq("cfg_rdata_o STATUS", rd, 8'h00);
  endtask

  task automatic test_static_write();
    i3c_header_u hdr;
    i3c_byte_t   b;
    logic        acked;
    clear_counts();
    hdr.raw = {sta_addr, 1'b0};
    send_start();
    send_header(hdr, acked);
    check_true(acked, "write header to the static address got no ACK");
    repeat (8) begin
      random_byte(b);
      exp_q.push_back(b);
      send_frame(b, good_tbit(b));
    end
    send_stop();
    wait_for_stop(1);
    check_queue();
    check_eq("bus_start_o pulses", start_cnt, 1);
    check_eq("bus_stop_o pulses", stop_cnt, 1);
    check_eq("bus_addr_valid_o pulses", addr_cnt, 1);
    check_eq("bus_addr_o", bus_addr.raw, hdr.raw);
  endtask

  task automatic test_no_ack();
    i3c_header_u hdr;
    i3c_byte_t   b;
    logic        acked;
    clear_counts();
    hdr.raw = {7'h33, 1'b0};
    send_start();
    send_header(hdr, acked);
    check_true(!acked, "header to a foreign address was acknowledged");
    random_byte(b);
    send_frame(b, good_tbit(b));
    send_stop();
    wait_for_stop(1);
    hdr.raw = {sta_addr, 1'b1};
    send_start();
    send_header(hdr, acked);
    check_true(!acked, "read header to the target was acknowledged");
    send_stop();
    wait_for_stop(2);
    check_queue();
    check_eq("bus_addr_valid_o pulses", addr_cnt, 2);
    check_eq("bus_addr_o", bus_addr.raw, hdr.raw);
  endtask

  task automatic test_parity();
    i3c_header_u hdr;
    i3c_byte_t   b;
    i3c_byte_t   st0;
    i3c_byte_t   st1;
    logic        acked;
    read_reg(STATUS, st0);
    clear_counts();
    hdr.raw = {sta_addr, 1'b0};
    send_start();
    send_header(hdr, acked);
    check_true(acked, "write header for the parity test got no ACK");
    for (int i = 0; i < 4; i++) begin
      random_byte(b);
      if (i % 2 == 0) begin
        exp_q.push_back(b);
        send_frame(b, good_tbit(b));
      end else begin
        send_frame(b, !good_tbit(b));
      end
    end
    send_stop();
    wait_for_stop(1);
    check_queue();
    check_eq("parity_err_o pulses", perr_cnt, 2);
    read_reg(STATUS, st1);
    check_eq("STATUS parity count", st1[3:0], st0[3:0] + 4'd2);
  endtask

  task automatic test_overflow();
    i3c_header_u hdr;
    i3c_byte_t   b;
    i3c_byte_t   st;
    logic        acked;
    clear_counts();
    queue_full = 1'b1;
    hdr.raw = {sta_addr, 1'b0};
    send_start();
    send_header(hdr, acked);
    check_true(acked, "write header for the overflow test got no ACK");
    repeat (3) begin
      random_byte(b);
      send_frame(b, good_tbit(b));
    end
    send_stop();
    wait_for_stop(1);
    queue_full = 1'b0;
    check_queue();
    read_reg(STATUS, st);
    check_eq("STATUS overflow flag", st[4], 1'b1);
    write_reg(STATUS, 8'h00);
    read_reg(STATUS, st);
    check_eq("cfg_rdata_o STATUS after clear", st, 8'h00);
  endtask

  task automatic test_rstart();
    i3c_header_u hdr;
    i3c_byte_t   b;
    logic        acked;
    clear_counts();
    hdr.raw = {sta_addr, 1'b0};
    send_start();
    send_header(hdr, acked);
    check_true(acked, "first header before the repeated START got no ACK");
    random_byte(b);
    exp_q.push_back(b);
    send_frame(b, good_tbit(b));
    send_rstart();
    hdr.raw = {dyn_addr, 1'b0};
    send_header(hdr, acked);
    check_true(acked, "header to the dynamic address got no ACK");
    repeat (2) begin
      random_byte(b);
      exp_q.push_back(b);
      send_frame(b, good_tbit(b));
    end
    send_stop();
    wait_for_stop(1);
    check_queue();
    check_eq("bus_rstart_o pulses", rstart_cnt, 1);
    check_eq("bus_start_o pulses", start_cnt, 1);
    check_eq("bus_addr_o", bus_addr.raw, hdr.raw);
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    scl        = 1'b1;
    sda_host   = 1'b1;
    cfg_we     = 1'b0;
    cfg_addr   = CTRL;
    cfg_wdata  = '0;
    queue_full = 1'b0;
    wait_clocks(3);
    rst_n = 1'b1;
    check_reset_state();
    test_registers();
    test_static_write();
    test_no_ack();
    test_parity();
    test_overflow();
    test_rstart();
    $display("Verification passed");
    $finish;
  end

endmodule

//--- files.f
+incdir+verilog
verilog/i3c_bus_pkg.sv
verilog/i3c_target_pkg.sv
verilog/bus_monitor.sv
verilog/bus_rx_flow.sv
verilog/target_fsm.sv
verilog/target_regs.sv
verilog/i3c_target_top.sv
bench/tb_i3c_target.sv

//--- verilog/bus_monitor.sv
// Conditions appear 2 to 3 clocks after the pins change; pins must be stable a few clocks
`timescale 1ns/1ps
`include "i3c_target_config.svh"

module bus_monitor (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic enable_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_o,
  output logic sda_o,
  output logic scl_rise_o,
  output logic scl_fall_o,
  output logic start_det_o,
  output logic rstart_det_o,
  output logic stop_det_o
);

  logic [`I3C_SYNC_STAGES-1:0] scl_sync_q;
  logic [`I3C_SYNC_STAGES-1:0] sda_sync_q;
  logic                        scl_prev_q;
  logic                        sda_prev_q;
  logic                        bus_busy_q;
  logic                        scl_high;
  logic                        sda_rise;
  logic                        sda_fall;

  // Idle bus is high, so the chain comes out of reset at 1
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[`I3C_SYNC_STAGES-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[`I3C_SYNC_STAGES-2:0], sda_i};
      scl_prev_q <= scl_o;
      sda_prev_q <= sda_o;
    end
  end

  assign scl_o = scl_sync_q[`I3C_SYNC_STAGES-1];
  assign sda_o = sda_sync_q[`I3C_SYNC_STAGES-1];

  assign scl_rise_o = scl_o & ~scl_prev_q;
  assign scl_fall_o = ~scl_o & scl_prev_q;

  // SCL held high across both samples
  assign scl_high = scl_o & scl_prev_q;
  assign sda_rise = sda_o & ~sda_prev_q;
  assign sda_fall = ~sda_o & sda_prev_q;

  assign start_det_o  = enable_i & scl_high & sda_fall & ~bus_busy_q;
  assign rstart_det_o = enable_i & scl_high & sda_fall & bus_busy_q;
  assign stop_det_o   = enable_i & scl_high & sda_rise;

  // Busy from START until STOP
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_busy_q <= 1'b0;
    end else if (!enable_i || stop_det_o) begin
      bus_busy_q <= 1'b0;
    end else if (start_det_o) begin
      bus_busy_q <= 1'b1;
    end
  end

  a_start_stop_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(start_det_o && stop_det_o));

endmodule

//--- verilog/bus_rx_flow.sv
// Samples SDA on SCL rising edges only; a request restarts any transfer in flight
`timescale 1ns/1ps
`include "i3c_target_config.svh"

module bus_rx_flow (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    scl_rise_i,
  input  logic                    sda_i,
  input  logic                    rx_req_byte_i,
  input  logic                    rx_req_frame_i,
  input  logic                    cancel_i,
  output logic                    rx_done_o,
  output logic [`I3C_FRAME_W-1:0] rx_data_o
);

  localparam int unsigned CntW = $clog2(`I3C_FRAME_W + 1);

  logic                    active_q;
  logic                    done_q;
  logic [CntW-1:0]         len_q;
  logic [CntW-1:0]         cnt_q;
  logic [CntW-1:0]         cnt_next;
  logic [`I3C_FRAME_W-1:0] shift_q;
  logic                    take_bit;
  logic                    req;

  assign req      = rx_req_byte_i | rx_req_frame_i;
  assign take_bit = active_q & scl_rise_i & ~cancel_i;
  assign cnt_next = cnt_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
      len_q    <= '0;
      cnt_q    <= '0;
    end else begin
      done_q <= 1'b0;
      if (cancel_i) begin
        active_q <= 1'b0;
      end else if (req) begin
        active_q <= 1'b1;
        cnt_q    <= '0;
        len_q    <= rx_req_frame_i ? CntW'(`I3C_FRAME_W) : CntW'(`I3C_BYTE_W);
      end else if (take_bit) begin
        cnt_q <= cnt_next;
        if (cnt_next == len_q) begin
          active_q <= 1'b0;
          done_q   <= 1'b1;
        end
      end
    end
  end

  // MSB first; a header lands in the low 8 bits
  always_ff @(posedge clk_i) begin
    if (req && !cancel_i) begin
      shift_q <= '0;
    end else if (take_bit) begin
      shift_q <= {shift_q[`I3C_FRAME_W-2:0], sda_i};
    end
  end

  assign rx_done_o = done_q;
  assign rx_data_o = shift_q;

endmodule

//--- verilog/i3c_bus_pkg.sv
// Bus-side types; the header layout is the I3C address byte with RnW in bit 0
`include "i3c_target_config.svh"

package i3c_bus_pkg;

  typedef logic [`I3C_BYTE_W-1:0] i3c_byte_t;
  typedef logic [`I3C_ADDR_W-1:0] i3c_addr_t;

  // Address byte seen raw or split into address and RnW
  typedef union packed {
    i3c_byte_t raw;
    struct packed {
      i3c_addr_t addr;
      logic      rnw;
    } hdr;
  } i3c_header_u;

endpackage

//--- verilog/i3c_target_config.svh
// Widths assume 7-bit addressing and SDR write frames of one byte plus a T bit
`ifndef I3C_TARGET_CONFIG_SVH
`define I3C_TARGET_CONFIG_SVH

// Bus framing
`define I3C_BYTE_W      8
`define I3C_FRAME_W     9
`define I3C_ADDR_W      7

// Input synchronizer depth, must be at least 2
`define I3C_SYNC_STAGES 2

// Register block
`define I3C_PERR_CNT_W  4
`define I3C_REG_ADDR_W  2

`endif

//--- verilog/i3c_target_pkg.sv
// Target-side types; the register map holds four byte-wide registers only
`include "i3c_target_config.svh"

package i3c_target_pkg;

  typedef enum logic [2:0] {
    IDLE,
    HEADER,
    HEADER_ACK,
    DATA,
    WAIT_STOP
  } target_state_e;

  // CTRL[0] enable
  // STA_ADDR/DYN_ADDR: [7] valid, [6:0] address
  // STATUS: [3:0] parity errors, [4] overflow, cleared on write
  typedef enum logic [`I3C_REG_ADDR_W-1:0] {
    CTRL     = 2'd0,
    STA_ADDR = 2'd1,
    DYN_ADDR = 2'd2,
    STATUS   = 2'd3
  } target_reg_e;

endpackage

//--- verilog/i3c_target_top.sv
// SDR private-write target; sda_i must be the wired-AND of host SDA and sda_o
`timescale 1ns/1ps
`include "i3c_target_config.svh"

module i3c_target_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        scl_i,
  input  logic                        sda_i,
  input  logic                        cfg_we_i,
  input  i3c_target_pkg::target_reg_e cfg_addr_i,
  input  i3c_bus_pkg::i3c_byte_t      cfg_wdata_i,
  input  logic                        rx_queue_full_i,
  output logic                        sda_o,
  output i3c_bus_pkg::i3c_byte_t      cfg_rdata_o,
  output logic                        rx_queue_wvalid_o,
  output i3c_bus_pkg::i3c_byte_t      rx_queue_wdata_o,
  output logic                        bus_start_o,
  output logic                        bus_rstart_o,
  output logic                        bus_stop_o,
  output i3c_bus_pkg::i3c_header_u    bus_addr_o,
  output logic                        bus_addr_valid_o,
  output logic                        parity_err_o
);
  import i3c_bus_pkg::*;

  logic                    enable;
  logic                    sda_sync;
  logic                    scl_rise;
  logic                    scl_fall;
  logic                    start_det;
  logic                    rstart_det;
  logic                    stop_det;
  logic                    rx_req_byte;
  logic                    rx_req_frame;
  logic                    rx_cancel;
  logic                    rx_done;
  logic [`I3C_FRAME_W-1:0] rx_data;
  i3c_addr_t               sta_addr;
  i3c_addr_t               dyn_addr;
  logic                    sta_addr_valid;
  logic                    dyn_addr_valid;
  logic                    parity_err;
  logic                    overflow;

  // Any bus condition aborts the frame being shifted in
  assign rx_cancel = start_det | rstart_det | stop_det;

  bus_monitor i_bus_monitor (
    .clk_i,
    .rst_ni,
    .enable_i    (enable),
    .scl_i,
    .sda_i,
    .scl_o       (),
    .sda_o       (sda_sync),
    .scl_rise_o  (scl_rise),
    .scl_fall_o  (scl_fall),
    .start_det_o (start_det),
    .rstart_det_o(rstart_det),
    .stop_det_o  (stop_det)
  );

  bus_rx_flow i_bus_rx_flow (
    .clk_i,
    .rst_ni,
    .scl_rise_i    (scl_rise),
    .sda_i         (sda_sync),
    .rx_req_byte_i (rx_req_byte),
    .rx_req_frame_i(rx_req_frame),
    .cancel_i      (rx_cancel),
    .rx_done_o     (rx_done),
    .rx_data_o     (rx_data)
  );

  target_fsm i_target_fsm (
    .clk_i,
    .rst_ni,
    .enable_i         (enable),
    .start_det_i      (start_det),
    .rstart_det_i     (rstart_det),
    .stop_det_i       (stop_det),
    .scl_fall_i       (scl_fall),
    .rx_done_i        (rx_done),
    .rx_data_i        (rx_data),
    .sta_addr_i       (sta_addr),
    .dyn_addr_i       (dyn_addr),
    .sta_addr_valid_i (sta_addr_valid),
    .dyn_addr_valid_i (dyn_addr_valid),
    .rx_queue_full_i,
    .rx_req_byte_o    (rx_req_byte),
    .rx_req_frame_o   (rx_req_frame),
    .sda_o,
    .rx_queue_wvalid_o,
    .rx_queue_wdata_o,
    .bus_addr_o,
    .bus_addr_valid_o,
    .parity_err_o     (parity_err),
    .overflow_o       (overflow)
  );

  target_regs i_target_regs (
    .clk_i,
    .rst_ni,
    .cfg_we_i,
    .cfg_addr_i,
    .cfg_wdata_i,
    .parity_err_i    (parity_err),
    .overflow_i      (overflow),
    .cfg_rdata_o,
    .enable_o        (enable),
    .sta_addr_valid_o(sta_addr_valid),
    .dyn_addr_valid_o(dyn_addr_valid),
    .sta_addr_o      (sta_addr),
    .dyn_addr_o      (dyn_addr)
  );

  assign bus_start_o  = start_det;
  assign bus_rstart_o = rstart_det;
  assign bus_stop_o   = stop_det;
  assign parity_err_o = parity_err;

endmodule

//--- verilog/target_fsm.sv
// Private writes only; read headers and other addresses are left unacknowledged
`timescale 1ns/1ps
`include "i3c_target_config.svh"

module target_fsm (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        enable_i,
  input  logic                        start_det_i,
  input  logic                        rstart_det_i,
  input  logic                        stop_det_i,
  input  logic                        scl_fall_i,
  input  logic                        rx_done_i,
  input  logic [`I3C_FRAME_W-1:0]     rx_data_i,
  input  i3c_bus_pkg::i3c_addr_t      sta_addr_i,
  input  i3c_bus_pkg::i3c_addr_t      dyn_addr_i,
  input  logic                        sta_addr_valid_i,
  input  logic                        dyn_addr_valid_i,
  input  logic                        rx_queue_full_i,
  output logic                        rx_req_byte_o,
  output logic                        rx_req_frame_o,
  output logic                        sda_o,
  output logic                        rx_queue_wvalid_o,
  output i3c_bus_pkg::i3c_byte_t      rx_queue_wdata_o,
  output i3c_bus_pkg::i3c_header_u    bus_addr_o,
  output logic                        bus_addr_valid_o,
  output logic                        parity_err_o,
  output logic                        overflow_o
);
  import i3c_bus_pkg::*;
  import i3c_target_pkg::*;

  target_state_e state_q;
  i3c_header_u   hdr_in;
  i3c_header_u   bus_addr_q;
  i3c_byte_t     frame_byte;
  i3c_byte_t     wdata_q;
  logic          frame_tbit;
  logic          parity_ok;
  logic          addr_match;
  logic          hdr_done;
  logic          frame_done;
  logic          sda_q;
  logic          rx_req_byte_q;
  logic          rx_req_frame_q;
  logic          parity_err_q;
  logic          byte_ready_q;

  assign hdr_in.raw = rx_data_i[`I3C_BYTE_W-1:0];
  assign frame_byte = rx_data_i[`I3C_FRAME_W-1:1];
  assign frame_tbit = rx_data_i[0];

  // T bit makes the frame odd parity
  assign parity_ok = (frame_tbit == ~^frame_byte);

  assign addr_match = (sta_addr_valid_i && (hdr_in.hdr.addr == sta_addr_i)) ||
                      (dyn_addr_valid_i && (hdr_in.hdr.addr == dyn_addr_i));

  assign hdr_done   = (state_q == HEADER) && rx_done_i;
  assign frame_done = (state_q == DATA) && rx_done_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= IDLE;
      sda_q          <= 1'b1;
      rx_req_byte_q  <= 1'b0;
      rx_req_frame_q <= 1'b0;
      parity_err_q   <= 1'b0;
      byte_ready_q   <= 1'b0;
    end else begin
      rx_req_byte_q  <= 1'b0;
      rx_req_frame_q <= 1'b0;
      parity_err_q   <= 1'b0;
      byte_ready_q   <= 1'b0;
      if (!enable_i) begin
        state_q <= IDLE;
        sda_q   <= 1'b1;
      end else if (start_det_i || rstart_det_i) begin
        state_q       <= HEADER;
        sda_q         <= 1'b1;
        rx_req_byte_q <= 1'b1;
      end else if (stop_det_i) begin
        state_q <= IDLE;
        sda_q   <= 1'b1;
      end else begin
        unique case (state_q)
          HEADER: begin
            if (rx_done_i) begin
              if (addr_match && !hdr_in.hdr.rnw) begin
                state_q <= HEADER_ACK;
              end else begin
                state_q <= WAIT_STOP;
              end
            end
          end
          // First fall pulls SDA for the ACK bit, second fall ends it
          HEADER_ACK: begin
            if (scl_fall_i) begin
              if (sda_q) begin
                sda_q <= 1'b0;
              end else begin
                sda_q          <= 1'b1;
                state_q        <= DATA;
                rx_req_frame_q <= 1'b1;
              end
            end
          end
          DATA: begin
            if (rx_done_i) begin
              rx_req_frame_q <= 1'b1;
              if (parity_ok) begin
                byte_ready_q <= 1'b1;
              end else begin
                parity_err_q <= 1'b1;
              end
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (hdr_done) begin
      bus_addr_q <= hdr_in;
    end
    if (frame_done) begin
      wdata_q <= frame_byte;
    end
  end

  assign rx_req_byte_o  = rx_req_byte_q;
  assign rx_req_frame_o = rx_req_frame_q;
  assign sda_o          = sda_q;

  // Header is visible in the cycle of its rx_done and held after
  assign bus_addr_valid_o = hdr_done;
  assign bus_addr_o       = hdr_done ? hdr_in : bus_addr_q;

  // Queue full is looked at in the strobe cycle itself
  assign rx_queue_wvalid_o = byte_ready_q & ~rx_queue_full_i;
  assign overflow_o        = byte_ready_q & rx_queue_full_i;
  assign rx_queue_wdata_o  = wdata_q;
  assign parity_err_o      = parity_err_q;

  a_ack_only: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !sda_o |-> state_q == HEADER_ACK);

  // A strobe needs room and a good frame the cycle before
  a_no_write_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_queue_wvalid_o |-> !rx_queue_full_i && $past(frame_done && parity_ok));

endmodule

//--- verilog/target_regs.sv
// Writes land on the clock edge with cfg_we_i; reads are combinational with no side effect
`timescale 1ns/1ps
`include "i3c_target_config.svh"

module target_regs (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        cfg_we_i,
  input  i3c_target_pkg::target_reg_e cfg_addr_i,
  input  i3c_bus_pkg::i3c_byte_t      cfg_wdata_i,
  input  logic                        parity_err_i,
  input  logic                        overflow_i,
  output i3c_bus_pkg::i3c_byte_t      cfg_rdata_o,
  output logic                        enable_o,
  output logic                        sta_addr_valid_o,
  output logic                        dyn_addr_valid_o,
  output i3c_bus_pkg::i3c_addr_t      sta_addr_o,
  output i3c_bus_pkg::i3c_addr_t      dyn_addr_o
);
  import i3c_bus_pkg::*;
  import i3c_target_pkg::*;

  logic                       enable_q;
  logic                       sta_valid_q;
  logic                       dyn_valid_q;
  i3c_addr_t                  sta_addr_q;
  i3c_addr_t                  dyn_addr_q;
  logic [`I3C_PERR_CNT_W-1:0] perr_cnt_q;
  logic                       ovf_q;
  logic                       status_wr;

  assign status_wr = cfg_we_i && (cfg_addr_i == STATUS);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q    <= 1'b0;
      sta_valid_q <= 1'b0;
      dyn_valid_q <= 1'b0;
      sta_addr_q  <= '0;
      dyn_addr_q  <= '0;
    end else if (cfg_we_i) begin
      unique case (cfg_addr_i)
        CTRL: enable_q <= cfg_wdata_i[0];
        STA_ADDR: begin
          sta_valid_q <= cfg_wdata_i[`I3C_ADDR_W];
          sta_addr_q  <= cfg_wdata_i[`I3C_ADDR_W-1:0];
        end
        DYN_ADDR: begin
          dyn_valid_q <= cfg_wdata_i[`I3C_ADDR_W];
          dyn_addr_q  <= cfg_wdata_i[`I3C_ADDR_W-1:0];
        end
        default: ;
      endcase
    end
  end

  // Error counter saturates, overflow is sticky until STATUS is written
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      perr_cnt_q <= '0;
      ovf_q      <= 1'b0;
    end else if (status_wr) begin
      perr_cnt_q <= '0;
      ovf_q      <= 1'b0;
    end else begin
      if (parity_err_i && (perr_cnt_q != '1)) begin
        perr_cnt_q <= perr_cnt_q + 1'b1;
      end
      if (overflow_i) begin
        ovf_q <= 1'b1;
      end
    end
  end

  always_comb begin
    cfg_rdata_o = '0;
    unique case (cfg_addr_i)
      CTRL:     cfg_rdata_o[0] = enable_q;
      STA_ADDR: cfg_rdata_o = {sta_valid_q, sta_addr_q};
      DYN_ADDR: cfg_rdata_o = {dyn_valid_q, dyn_addr_q};
      STATUS:   cfg_rdata_o[`I3C_PERR_CNT_W:0] = {ovf_q, perr_cnt_q};
      default: ;
    endcase
  end

  assign enable_o         = enable_q;
  assign sta_addr_valid_o = sta_valid_q;
  assign dyn_addr_valid_o = dyn_valid_q;
  assign sta_addr_o       = sta_addr_q;
  assign dyn_addr_o       = dyn_addr_q;

  a_perr_no_wrap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (perr_cnt_q == '1 && !status_wr) |=> perr_cnt_q == '1);

endmodule
